// File: Bender.yml
package:
  name: lc3b_core

sources:
  - lc3b_pkg.sv
  - lc3b_fetch.sv
  - lc3b_regfile.sv
  - lc3b_decode.sv
  - lc3b_execute.sv
  - lc3b_result.sv
  - lc3b_core.sv
  - target: test
    files:
      - tb_mem_model.sv
      - tb_lc3b_core.sv

// File: all.f
lc3b_pkg.sv
lc3b_fetch.sv
lc3b_regfile.sv
lc3b_decode.sv
lc3b_execute.sv
lc3b_result.sv
lc3b_core.sv
tb_mem_model.sv
tb_lc3b_core.sv

// File: lc3b_core.sv
`timescale 1ns/1ps
`default_nettype none

module lc3b_core
(
    input  wire                     clk,
    input  wire                     arst_n,
    output logic                    imem_req,
    output lc3b_pkg::lc3b_word      imem_addr,
    input  wire                     imem_ack,
    input  wire lc3b_pkg::lc3b_word imem_rdata,
    output logic                    dmem_req,
    output logic                    dmem_we,
    output lc3b_pkg::lc3b_word      dmem_addr,
    output lc3b_pkg::lc3b_word      dmem_wdata,
    input  wire                     dmem_ack,
    input  wire lc3b_pkg::lc3b_word dmem_rdata
);

    logic                 step;
    logic                 flush;
    logic                 fetch_done;
    logic                 mem_done;
    logic                 branch_taken;
    lc3b_pkg::lc3b_word   branch_target;
    lc3b_pkg::lc3b_word   instr;
    lc3b_pkg::lc3b_word   fetch_pc;
    lc3b_pkg::lc3b_reg    src_a;
    lc3b_pkg::lc3b_reg    src_b;
    lc3b_pkg::lc3b_word   reg_a;
    lc3b_pkg::lc3b_word   reg_b;
    lc3b_pkg::lc3b_opcode d_opcode;
    lc3b_pkg::lc3b_aluop  d_aluop;
    lc3b_pkg::lc3b_wbsel  d_wbsel;
    logic                 d_reg_we;
    logic                 d_mem_rd;
    logic                 d_mem_wr;
    logic                 d_imm_en;
    lc3b_pkg::lc3b_nzp    d_nzp;
    lc3b_pkg::lc3b_reg    d_dest;
    lc3b_pkg::lc3b_word   d_op_a;
    lc3b_pkg::lc3b_word   d_op_b;
    lc3b_pkg::lc3b_word   d_pc;
    lc3b_pkg::lc3b_word   d_ir;
    lc3b_pkg::lc3b_word   e_alu;
    lc3b_pkg::lc3b_word   e_addr;
    lc3b_pkg::lc3b_word   e_store;
    lc3b_pkg::lc3b_reg    e_dest;
    lc3b_pkg::lc3b_wbsel  e_wbsel;
    logic                 e_reg_we;
    logic                 e_mem_rd;
    logic                 e_mem_wr;
    lc3b_pkg::lc3b_nzp    e_nzp;
    logic                 e_is_br;
    logic                 rf_we;
    lc3b_pkg::lc3b_reg    rf_dest;
    lc3b_pkg::lc3b_word   rf_wdata;

    // every stage register moves together once both ports are idle
    assign step  = fetch_done & mem_done;
    assign flush = branch_taken;

    lc3b_fetch i_fetch (.*);

    lc3b_regfile i_regfile
    (
        .clk    (clk),
        .arst_n (arst_n),
        .src_a  (src_a),
        .src_b  (src_b),
        .reg_a  (reg_a),
        .reg_b  (reg_b),
        .we     (rf_we),
        .dest   (rf_dest),
        .wdata  (rf_wdata)
    );

    lc3b_decode i_decode (.*);

    lc3b_execute i_execute (.*);

    lc3b_result i_result (.*);

endmodule

`default_nettype wire

// File: lc3b_decode.sv
`timescale 1ns/1ps
`default_nettype none

module lc3b_decode
(
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     step,
    input  wire                     flush,
    input  wire lc3b_pkg::lc3b_word instr,
    input  wire lc3b_pkg::lc3b_word fetch_pc,
    output lc3b_pkg::lc3b_reg       src_a,
    output lc3b_pkg::lc3b_reg       src_b,
    input  wire lc3b_pkg::lc3b_word reg_a,
    input  wire lc3b_pkg::lc3b_word reg_b,
    output lc3b_pkg::lc3b_opcode    d_opcode,
    output lc3b_pkg::lc3b_aluop     d_aluop,
    output lc3b_pkg::lc3b_wbsel     d_wbsel,
    output logic                    d_reg_we,
    output logic                    d_mem_rd,
    output logic                    d_mem_wr,
    output logic                    d_imm_en,
    output lc3b_pkg::lc3b_nzp       d_nzp,
    output lc3b_pkg::lc3b_reg       d_dest,
    output lc3b_pkg::lc3b_word      d_op_a,
    output lc3b_pkg::lc3b_word      d_op_b,
    output lc3b_pkg::lc3b_word      d_pc,
    output lc3b_pkg::lc3b_word      d_ir
);

    lc3b_pkg::lc3b_word   ir;
    lc3b_pkg::lc3b_word   ir_pc;
    lc3b_pkg::lc3b_opcode opcode;
    lc3b_pkg::lc3b_aluop  aluop;
    lc3b_pkg::lc3b_wbsel  wbsel;
    logic                 reg_we;
    logic                 mem_rd;
    logic                 mem_wr;
    logic                 imm_en;
    lc3b_pkg::lc3b_nzp    nzp;

    // a taken branch replaces the wrong-path word with a nop
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            ir <= lc3b_pkg::nop_instr;
        else if (step)
            ir <= flush ? lc3b_pkg::nop_instr : instr;
    end

    always_ff @(posedge clk)
    begin
        if (step)
            ir_pc <= fetch_pc;
    end

    always_comb
    begin
        opcode = lc3b_pkg::op_br;                 // unknown opcodes become nops
        aluop  = lc3b_pkg::alu_pass;
        wbsel  = lc3b_pkg::wb_alu;
        reg_we = 1'b0;
        mem_rd = 1'b0;
        mem_wr = 1'b0;
        imm_en = 1'b0;
        nzp    = '0;
        case (lc3b_pkg::lc3b_opcode'(ir[15:12]))
            lc3b_pkg::op_add:
            begin
                opcode = lc3b_pkg::op_add;
                aluop  = lc3b_pkg::alu_add;
                reg_we = 1'b1;
                imm_en = ir[5];
            end
            lc3b_pkg::op_and:
            begin
                opcode = lc3b_pkg::op_and;
                aluop  = lc3b_pkg::alu_and;
                reg_we = 1'b1;
                imm_en = ir[5];
            end
            lc3b_pkg::op_not:
            begin
                opcode = lc3b_pkg::op_not;
                aluop  = lc3b_pkg::alu_not;
                reg_we = 1'b1;
            end
            lc3b_pkg::op_ldr:
            begin
                opcode = lc3b_pkg::op_ldr;
                wbsel  = lc3b_pkg::wb_mem;
                reg_we = 1'b1;
                mem_rd = 1'b1;
            end
            lc3b_pkg::op_str:
            begin
                opcode = lc3b_pkg::op_str;
                mem_wr = 1'b1;
            end
            lc3b_pkg::op_lea:
            begin
                opcode = lc3b_pkg::op_lea;
                wbsel  = lc3b_pkg::wb_addr;
                reg_we = 1'b1;
            end
            lc3b_pkg::op_br:
                nzp = ir[11:9];
            default:
                nzp = '0;
        endcase
    end

    assign src_a = ir[8:6];                                       // sr1 or base
    assign src_b = (ir[15:12] == lc3b_pkg::op_str) ? ir[11:9] : ir[2:0];  // store mux

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            d_opcode <= lc3b_pkg::op_br;
            d_aluop  <= lc3b_pkg::alu_pass;
            d_wbsel  <= lc3b_pkg::wb_alu;
            d_reg_we <= 1'b0;
            d_mem_rd <= 1'b0;
            d_mem_wr <= 1'b0;
            d_imm_en <= 1'b0;
            d_nzp    <= '0;
        end
        else if (step)
        begin
            if (flush)
            begin
                d_opcode <= lc3b_pkg::op_br;
                d_aluop  <= lc3b_pkg::alu_pass;
                d_wbsel  <= lc3b_pkg::wb_alu;
            end
            else
            begin
                d_opcode <= opcode;
                d_aluop  <= aluop;
                d_wbsel  <= wbsel;
            end
            d_reg_we <= reg_we & ~flush;
            d_mem_rd <= mem_rd & ~flush;
            d_mem_wr <= mem_wr & ~flush;
            d_imm_en <= imm_en & ~flush;
            d_nzp    <= flush ? 3'b000 : nzp;
        end
    end

    always_ff @(posedge clk)
    begin
        if (step)
        begin
            d_dest <= ir[11:9];
            d_op_a <= reg_a;
            d_op_b <= reg_b;
            d_pc   <= ir_pc;
            d_ir   <= ir;
        end
    end

endmodule

`default_nettype wire

// File: lc3b_execute.sv
`timescale 1ns/1ps
`default_nettype none

module lc3b_execute
(
    input  wire                       clk,
    input  wire                       arst_n,
    input  wire                       step,
    input  wire                       flush,
    input  wire lc3b_pkg::lc3b_opcode d_opcode,
    input  wire lc3b_pkg::lc3b_aluop  d_aluop,
    input  wire lc3b_pkg::lc3b_wbsel  d_wbsel,
    input  wire                       d_reg_we,
    input  wire                       d_mem_rd,
    input  wire                       d_mem_wr,
    input  wire                       d_imm_en,
    input  wire lc3b_pkg::lc3b_nzp    d_nzp,
    input  wire lc3b_pkg::lc3b_reg    d_dest,
    input  wire lc3b_pkg::lc3b_word   d_op_a,
    input  wire lc3b_pkg::lc3b_word   d_op_b,
    input  wire lc3b_pkg::lc3b_word   d_pc,
    input  wire lc3b_pkg::lc3b_word   d_ir,
    output lc3b_pkg::lc3b_word        e_alu,
    output lc3b_pkg::lc3b_word        e_addr,
    output lc3b_pkg::lc3b_word        e_store,
    output lc3b_pkg::lc3b_reg         e_dest,
    output lc3b_pkg::lc3b_wbsel       e_wbsel,
    output logic                      e_reg_we,
    output logic                      e_mem_rd,
    output logic                      e_mem_wr,
    output lc3b_pkg::lc3b_nzp         e_nzp,
    output logic                      e_is_br
);

    lc3b_pkg::lc3b_imm5    imm5;
    lc3b_pkg::lc3b_offset6 offset6;
    lc3b_pkg::lc3b_offset9 offset9;
    lc3b_pkg::lc3b_word    sext5;
    lc3b_pkg::lc3b_word    adj6;
    lc3b_pkg::lc3b_word    adj9;
    lc3b_pkg::lc3b_word    alu_b;
    lc3b_pkg::lc3b_word    alu_out;
    lc3b_pkg::lc3b_word    addr_out;
    logic                  use_base;

    assign imm5    = d_ir[4:0];
    assign offset6 = d_ir[5:0];
    assign offset9 = d_ir[8:0];

    assign sext5 = {{11{imm5[4]}}, imm5};
    assign adj6  = {{9{offset6[5]}}, offset6, 1'b0};   // word offset to bytes
    assign adj9  = {{6{offset9[8]}}, offset9, 1'b0};

    assign alu_b = d_imm_en ? sext5 : d_op_b;

    always_comb
    begin
        case (d_aluop)
            lc3b_pkg::alu_add: alu_out = d_op_a + alu_b;
            lc3b_pkg::alu_and: alu_out = d_op_a & alu_b;
            lc3b_pkg::alu_not: alu_out = ~d_op_a;
            default:           alu_out = d_op_a;
        endcase
    end

    // ldr/str add to the base register, br/lea to the pc
    assign use_base = (d_opcode == lc3b_pkg::op_ldr) || (d_opcode == lc3b_pkg::op_str);
    assign addr_out = use_base ? d_op_a + adj6 : d_pc + adj9;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            e_wbsel  <= lc3b_pkg::wb_alu;
            e_reg_we <= 1'b0;
            e_mem_rd <= 1'b0;
            e_mem_wr <= 1'b0;
            e_nzp    <= '0;
            e_is_br  <= 1'b0;
        end
        else if (step)
        begin
            e_wbsel  <= flush ? lc3b_pkg::wb_alu : d_wbsel;
            e_reg_we <= d_reg_we & ~flush;
            e_mem_rd <= d_mem_rd & ~flush;
            e_mem_wr <= d_mem_wr & ~flush;
            e_nzp    <= flush ? 3'b000 : d_nzp;
            e_is_br  <= (d_opcode == lc3b_pkg::op_br) & ~flush;
        end
    end

    always_ff @(posedge clk)
    begin
        if (step)
        begin
            e_alu   <= alu_out;
            e_addr  <= addr_out;
            e_store <= d_op_b;   // register picked by the store mux in decode
            e_dest  <= d_dest;
        end
    end

    a_mem_rd_wr_excl: assert property (@(posedge clk) disable iff (!arst_n)
        !(d_mem_rd && d_mem_wr));

endmodule

`default_nettype wire

// File: lc3b_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module lc3b_fetch
(
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     step,
    input  wire                     branch_taken,
    input  wire lc3b_pkg::lc3b_word branch_target,
    output logic                    imem_req,
    output lc3b_pkg::lc3b_word      imem_addr,
    input  wire                     imem_ack,
    input  wire lc3b_pkg::lc3b_word imem_rdata,
    output lc3b_pkg::lc3b_word      instr,
    output lc3b_pkg::lc3b_word      fetch_pc,
    output logic                    fetch_done
);

    typedef enum logic [1:0]
    {
        f_idle,
        f_req,
        f_release,
        f_done
    } fetch_state_t;

    fetch_state_t       state;
    lc3b_pkg::lc3b_word pc;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state <= f_idle;
            pc    <= lc3b_pkg::reset_pc;
        end
        else
        begin
            case (state)
                f_idle:
                    state <= f_req;
                f_req:
                    if (imem_ack)
                        state <= f_release;
                f_release:
                    if (!imem_ack)
                        state <= f_done;
                default:
                    if (step)
                        state <= f_req;          // next slot starts at the new pc
            endcase

            if (step)
                pc <= branch_taken ? branch_target : fetch_pc;
        end
    end

    // holds the fetched word until decode takes it on step
    always_ff @(posedge clk)
    begin
        if (state == f_req && imem_ack)
            instr <= imem_rdata;
    end

    assign imem_req   = (state == f_req);
    assign imem_addr  = pc;
    assign fetch_pc   = pc + 16'd2;
    assign fetch_done = (state == f_done);

    a_imem_addr_stable: assert property (@(posedge clk) disable iff (!arst_n)
        imem_req |=> $stable(imem_addr));

endmodule

`default_nettype wire

// File: lc3b_pkg.sv
`default_nettype none

package lc3b_pkg;

    typedef logic [15:0] lc3b_word;      // data or address word
    typedef logic [2:0]  lc3b_reg;       // register index
    typedef logic [2:0]  lc3b_nzp;       // n, z, p from msb down
    typedef logic [4:0]  lc3b_imm5;
    typedef logic [5:0]  lc3b_offset6;   // ldr/str word offset
    typedef logic [8:0]  lc3b_offset9;   // br/lea word offset

    typedef enum logic [3:0]
    {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001,
        op_lea = 4'b1110
    } lc3b_opcode;

    typedef enum logic [1:0]
    {
        alu_add,
        alu_and,
        alu_not,
        alu_pass
    } lc3b_aluop;

    // writeback source in the result stage
    typedef enum logic [1:0]
    {
        wb_alu,
        wb_mem,
        wb_addr
    } lc3b_wbsel;

    typedef enum logic [1:0]
    {
        m_idle,
        m_req,      // req high, waiting for ack
        m_release   // req low, waiting for ack to drop
    } mem_state_t;

    localparam lc3b_word reset_pc  = 16'h0000;
    localparam lc3b_word nop_instr = 16'h0000;   // br with empty nzp mask

endpackage

`default_nettype wire

// File: lc3b_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module lc3b_regfile
(
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire lc3b_pkg::lc3b_reg  src_a,
    input  wire lc3b_pkg::lc3b_reg  src_b,
    output lc3b_pkg::lc3b_word      reg_a,
    output lc3b_pkg::lc3b_word      reg_b,
    input  wire                     we,
    input  wire lc3b_pkg::lc3b_reg  dest,
    input  wire lc3b_pkg::lc3b_word wdata
);

    lc3b_pkg::lc3b_word regs [8];

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < 8; i++)
                regs[i] <= '0;
        end
        else if (we)
        begin
            regs[dest] <= wdata;
        end
    end

    // no bypass, software spaces dependent reads
    assign reg_a = regs[src_a];
    assign reg_b = regs[src_b];

endmodule

`default_nettype wire

// File: lc3b_result.sv
`timescale 1ns/1ps
`default_nettype none

module lc3b_result
(
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     step,
    input  wire lc3b_pkg::lc3b_word e_alu,
    input  wire lc3b_pkg::lc3b_word e_addr,
    input  wire lc3b_pkg::lc3b_word e_store,
    input  wire lc3b_pkg::lc3b_reg  e_dest,
    input  wire lc3b_pkg::lc3b_wbsel e_wbsel,
    input  wire                     e_reg_we,
    input  wire                     e_mem_rd,
    input  wire                     e_mem_wr,
    input  wire lc3b_pkg::lc3b_nzp  e_nzp,
    input  wire                     e_is_br,
    output logic                    dmem_req,
    output logic                    dmem_we,
    output lc3b_pkg::lc3b_word      dmem_addr,
    output lc3b_pkg::lc3b_word      dmem_wdata,
    input  wire                     dmem_ack,
    input  wire lc3b_pkg::lc3b_word dmem_rdata,
    output logic                    mem_done,
    output logic                    rf_we,
    output lc3b_pkg::lc3b_reg       rf_dest,
    output lc3b_pkg::lc3b_word      rf_wdata,
    output logic                    branch_taken,
    output lc3b_pkg::lc3b_word      branch_target
);

    lc3b_pkg::mem_state_t state;
    logic                 mem_op;
    logic                 served;     // handshake finished in this slot
    lc3b_pkg::lc3b_word   mdr;
    lc3b_pkg::lc3b_nzp    cc;
    lc3b_pkg::lc3b_nzp    gencc;

    assign mem_op = e_mem_rd | e_mem_wr;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state  <= lc3b_pkg::m_idle;
            served <= 1'b0;
        end
        else
        begin
            case (state)
                lc3b_pkg::m_idle:
                    if (mem_op && !served)
                        state <= lc3b_pkg::m_req;
                lc3b_pkg::m_req:
                    if (dmem_ack)
                        state <= lc3b_pkg::m_release;
                default:
                    if (!dmem_ack)
                        state <= lc3b_pkg::m_idle;
            endcase

            if (step)
                served <= 1'b0;
            else if (state == lc3b_pkg::m_release && !dmem_ack)
                served <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == lc3b_pkg::m_req && dmem_ack && e_mem_rd)
            mdr <= dmem_rdata;
    end

    assign dmem_req   = (state == lc3b_pkg::m_req);
    assign dmem_we    = e_mem_wr;
    assign dmem_addr  = e_addr;
    assign dmem_wdata = e_store;
    assign mem_done   = served | ~mem_op;

    always_comb
    begin
        case (e_wbsel)
            lc3b_pkg::wb_mem:  rf_wdata = mdr;
            lc3b_pkg::wb_addr: rf_wdata = e_addr;
            default:           rf_wdata = e_alu;
        endcase
    end

    assign rf_we   = e_reg_we & step;   // write lands on the closing edge of the slot
    assign rf_dest = e_dest;

    assign gencc = rf_wdata[15] ? 3'b100 : (rf_wdata == 16'h0000) ? 3'b010 : 3'b001;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            cc <= 3'b010;
        else if (rf_we)
            cc <= gencc;
    end

    assign branch_taken  = e_is_br & |(e_nzp & cc);
    assign branch_target = e_addr;

    a_dmem_req_after_ack: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(dmem_req) |-> !dmem_ack);

endmodule

`default_nettype wire

// File: tb_lc3b_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lc3b_core;

    logic               clk;
    logic               arst_n;
    logic               imem_req;
    lc3b_pkg::lc3b_word imem_addr;
    logic               imem_ack;
    lc3b_pkg::lc3b_word imem_rdata;
    logic               dmem_req;
    logic               dmem_we;
    lc3b_pkg::lc3b_word dmem_addr;
    lc3b_pkg::lc3b_word dmem_wdata;
    logic               dmem_ack;
    lc3b_pkg::lc3b_word dmem_rdata;

    lc3b_pkg::lc3b_word prog [$];        // program under construction
    int                 errors = 0;
    int                 checks = 0;
    int                 cycles = 0;
    int                 cycle_limit = 0;
    logic               imem_req_q = 1'b0;
    logic               dmem_req_q = 1'b0;
    lc3b_pkg::lc3b_word imem_addr_q;
    lc3b_pkg::lc3b_word dmem_addr_q;

    lc3b_core i_dut
    (
        .clk        (clk),
        .arst_n     (arst_n),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_ack   (imem_ack),
        .imem_rdata (imem_rdata),
        .dmem_req   (dmem_req),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_ack   (dmem_ack),
        .dmem_rdata (dmem_rdata)
    );

    tb_mem_model i_rom
    (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (imem_req),
        .we     (1'b0),
        .addr   (imem_addr),
        .wdata  (16'h0000),
        .ack    (imem_ack),
        .rdata  (imem_rdata)
    );

    tb_mem_model i_ram
    (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (dmem_req),
        .we     (dmem_we),
        .addr   (dmem_addr),
        .wdata  (dmem_wdata),
        .ack    (dmem_ack),
        .rdata  (dmem_rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_word(input string name, input lc3b_pkg::lc3b_word got,
                              input lc3b_pkg::lc3b_word exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_ram(input lc3b_pkg::lc3b_word addr, input lc3b_pkg::lc3b_word exp);
        check_word($sformatf("ram[%h]", addr), i_ram.mem[addr[8:1]], exp);
    endtask

    // handshake rules at both ports, sampled before the edge updates
    always @(posedge clk)
    begin
        if (arst_n)
        begin
            if (imem_req && imem_req_q)
                check_word("imem_addr", imem_addr, imem_addr_q);
            if (dmem_req && dmem_req_q)
                check_word("dmem_addr", dmem_addr, dmem_addr_q);
            if (dmem_ack && !dmem_req_q)
                check_flag("dmem_req", dmem_req, 1'b0);    // ack still up from last access
            if (dmem_req && !dmem_req_q)
                check_flag("dmem_ack", dmem_ack, 1'b0);
        end
        imem_req_q  = imem_req;
        dmem_req_q  = dmem_req;
        imem_addr_q = imem_addr;
        dmem_addr_q = dmem_addr;
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles > cycle_limit)
        begin
            $display("timeout: the program did not reach its final store in %0d cycles", cycles);
            $display("Errors found");
            $finish;
        end
    end

    function automatic lc3b_pkg::lc3b_word alu_reg_word(input lc3b_pkg::lc3b_opcode op,
        input lc3b_pkg::lc3b_reg dr, input lc3b_pkg::lc3b_reg sr1, input lc3b_pkg::lc3b_reg sr2);
        return {op, dr, sr1, 3'b000, sr2};
    endfunction

    function automatic lc3b_pkg::lc3b_word alu_imm_word(input lc3b_pkg::lc3b_opcode op,
        input lc3b_pkg::lc3b_reg dr, input lc3b_pkg::lc3b_reg sr1, input logic [4:0] imm);
        return {op, dr, sr1, 1'b1, imm};
    endfunction

    function automatic lc3b_pkg::lc3b_word not_word(input lc3b_pkg::lc3b_reg dr,
                                                    input lc3b_pkg::lc3b_reg sr);
        return {lc3b_pkg::op_not, dr, sr, 6'b111111};
    endfunction

    function automatic lc3b_pkg::lc3b_word mem_word(input lc3b_pkg::lc3b_opcode op,
        input lc3b_pkg::lc3b_reg r, input lc3b_pkg::lc3b_reg base, input logic [5:0] off);
        return {op, r, base, off};
    endfunction

    function automatic lc3b_pkg::lc3b_word lea_word(input lc3b_pkg::lc3b_reg dr,
                                                    input logic [8:0] off);
        return {lc3b_pkg::op_lea, dr, off};
    endfunction

    function automatic lc3b_pkg::lc3b_word br_word(input lc3b_pkg::lc3b_nzp nzp,
                                                   input logic [8:0] off);
        return {lc3b_pkg::op_br, nzp, off};
    endfunction

    // ~address, so every word differs from its neighbours
    function automatic lc3b_pkg::lc3b_word ram_fill(input int idx);
        return ~lc3b_pkg::lc3b_word'(idx * 2);
    endfunction

    // br with empty mask, never taken
    function automatic lc3b_pkg::lc3b_word rom_fill(input int idx);
        return lc3b_pkg::lc3b_word'(idx);
    endfunction

    task automatic emit(input lc3b_pkg::lc3b_word word);
        prog.push_back(word);
    endtask

    task automatic add_nops(input int count);
        repeat (count) emit(lc3b_pkg::nop_instr);
    endtask

    task automatic preload_ram(input lc3b_pkg::lc3b_word addr, input lc3b_pkg::lc3b_word data);
        i_ram.mem[addr[8:1]] = data;
    endtask

    task automatic start_test();
        int idx;
        cycle_limit += 12;                   // reset hold and gap between tests
        @(negedge clk);
        arst_n = 1'b0;
        prog.delete();
        for (idx = 0; idx < 256; idx++)
            i_ram.mem[idx] = ram_fill(idx);
    endtask

    // appends the final store and the spin loop, then runs until that store lands
    task automatic run_program();
        int idx;
        emit(mem_word(lc3b_pkg::op_str, 0, 0, 6'd31));   // marker store to 0x3e
        emit(br_word(3'b111, 9'h1ff));                  // branch to self
        for (idx = 0; idx < 256; idx++)
            i_rom.mem[idx] = (idx < prog.size()) ? prog[idx] : rom_fill(idx);
        cycle_limit += 40 * (prog.size() + 3);
        repeat (10) @(negedge clk);
        check_flag("imem_req", imem_req, 1'b0);
        check_flag("dmem_req", dmem_req, 1'b0);
        arst_n = 1'b1;
        @(negedge clk);
        check_flag("imem_req", imem_req, 1'b1);
        do
            @(posedge clk);
        while (!(dmem_ack && dmem_we && dmem_addr == 16'h003e));
        check_ram(16'h003e, 16'h0000);
    endtask

    task automatic test_alu();
        lc3b_pkg::lc3b_word a;
        lc3b_pkg::lc3b_word b;
        a = 16'd13;
        b = lc3b_pkg::lc3b_word'(-6);
        start_test();
        emit(alu_imm_word(lc3b_pkg::op_add, 1, 0, 5'd13));
        emit(alu_imm_word(lc3b_pkg::op_add, 2, 0, 5'(-6)));
        add_nops(3);
        emit(alu_reg_word(lc3b_pkg::op_add, 3, 1, 2));
        emit(alu_reg_word(lc3b_pkg::op_and, 4, 1, 2));
        emit(not_word(5, 2));
        emit(alu_imm_word(lc3b_pkg::op_and, 6, 2, 5'(-3)));
        emit(alu_imm_word(lc3b_pkg::op_add, 7, 1, 5'(-16)));
        emit(mem_word(lc3b_pkg::op_str, 1, 0, 6'd0));
        emit(mem_word(lc3b_pkg::op_str, 2, 0, 6'd1));
        emit(mem_word(lc3b_pkg::op_str, 3, 0, 6'd2));
        emit(mem_word(lc3b_pkg::op_str, 4, 0, 6'd3));
        emit(mem_word(lc3b_pkg::op_str, 5, 0, 6'd4));
        emit(mem_word(lc3b_pkg::op_str, 6, 0, 6'd5));
        emit(mem_word(lc3b_pkg::op_str, 7, 0, 6'd6));
        run_program();
        check_ram(16'h0000, a);
        check_ram(16'h0002, b);
        check_ram(16'h0004, a + b);
        check_ram(16'h0006, a & b);
        check_ram(16'h0008, ~b);
        check_ram(16'h000a, b & lc3b_pkg::lc3b_word'(-3));
        check_ram(16'h000c, a + lc3b_pkg::lc3b_word'(-16));
    endtask

    task automatic test_load();
        lc3b_pkg::lc3b_word base;
        lc3b_pkg::lc3b_word data;
        base = 16'd10;
        data = 16'h1234;
        start_test();
        preload_ram(base + (16'd3 << 1), data);
        emit(alu_imm_word(lc3b_pkg::op_add, 6, 0, 5'd10));
        emit(alu_imm_word(lc3b_pkg::op_add, 1, 0, 5'd5));
        add_nops(3);
        emit(mem_word(lc3b_pkg::op_ldr, 2, 6, 6'd3));
        add_nops(3);
        emit(alu_reg_word(lc3b_pkg::op_add, 3, 2, 1));
        emit(mem_word(lc3b_pkg::op_str, 2, 6, 6'(-2)));   // negative offset
        add_nops(2);
        emit(mem_word(lc3b_pkg::op_str, 3, 0, 6'd12));
        run_program();
        check_ram(16'h0018, data + 16'd5);
        check_ram(base + lc3b_pkg::lc3b_word'(-4), data);
    endtask

    task automatic test_lea();
        lc3b_pkg::lc3b_word pc1;
        lc3b_pkg::lc3b_word pc2;
        start_test();
        add_nops(1);
        pc1 = lc3b_pkg::lc3b_word'(prog.size() * 2);
        emit(lea_word(1, 9'd20));
        pc2 = lc3b_pkg::lc3b_word'(prog.size() * 2);
        emit(lea_word(2, 9'(-3)));
        add_nops(3);
        emit(mem_word(lc3b_pkg::op_str, 1, 0, 6'd1));
        emit(mem_word(lc3b_pkg::op_str, 2, 0, 6'd2));
        run_program();
        check_ram(16'h0002, pc1 + 16'd2 + 16'd40);
        check_ram(16'h0004, pc2 + 16'd2 - 16'd6);
    endtask

    task automatic test_branch();
        start_test();
        emit(alu_imm_word(lc3b_pkg::op_add, 1, 0, 5'd7));
        add_nops(3);
        emit(alu_imm_word(lc3b_pkg::op_add, 2, 0, 5'(-1)));   // codes to n
        emit(br_word(3'b100, 9'd2));                          // taken
        emit(mem_word(lc3b_pkg::op_str, 1, 0, 6'd4));
        emit(mem_word(lc3b_pkg::op_str, 1, 0, 6'd5));
        emit(mem_word(lc3b_pkg::op_str, 1, 0, 6'd6));
        emit(alu_imm_word(lc3b_pkg::op_add, 3, 0, 5'd0));     // codes to z
        emit(br_word(3'b001, 9'd2));                          // not taken
        emit(mem_word(lc3b_pkg::op_str, 1, 0, 6'd7));
        emit(mem_word(lc3b_pkg::op_str, 1, 0, 6'd8));
        run_program();
        check_ram(16'h0008, ram_fill(4));
        check_ram(16'h000a, ram_fill(5));
        check_ram(16'h000c, 16'd7);
        check_ram(16'h000e, 16'd7);
        check_ram(16'h0010, 16'd7);
    endtask

    initial
    begin
        arst_n = 1'b0;
        test_alu();
        test_load();
        test_lea();
        test_branch();
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model
(
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     req,
    input  wire                     we,
    input  wire lc3b_pkg::lc3b_word addr,
    input  wire lc3b_pkg::lc3b_word wdata,
    output logic                    ack,
    output lc3b_pkg::lc3b_word      rdata
);

    lc3b_pkg::lc3b_word   mem [256];   // word array, byte address bit 0 ignored
    lc3b_pkg::mem_state_t state;
    integer               seed;
    logic [31:0]          rnd;
    logic [1:0]           wait_cnt;    // extra cycles before ack rises or falls

    initial
    begin
        seed = 32'h686c605e;
    end

    // responder side of the four-phase handshake, driven on the falling edge
    always @(negedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state    <= lc3b_pkg::m_idle;
            ack      <= 1'b0;
            rdata    <= '0;
            wait_cnt <= '0;
        end
        else
        begin
            case (state)
                lc3b_pkg::m_idle:
                    if (req)
                    begin
                        rnd = $random(seed);
                        wait_cnt <= rnd[1:0];
                        state    <= lc3b_pkg::m_req;
                    end
                lc3b_pkg::m_req:
                    if (wait_cnt != 2'd0)
                    begin
                        wait_cnt <= wait_cnt - 2'd1;
                    end
                    else
                    begin
                        if (we)
                            mem[addr[8:1]] = wdata;
                        rdata <= mem[addr[8:1]];
                        ack   <= 1'b1;
                        rnd = $random(seed);
                        wait_cnt <= rnd[1:0];   // ack hold time once req falls
                        state <= lc3b_pkg::m_release;
                    end
                default:
                    if (!req)
                    begin
                        if (wait_cnt != 2'd0)
                        begin
                            wait_cnt <= wait_cnt - 2'd1;
                        end
                        else
                        begin
                            ack   <= 1'b0;   // requester let go
                            state <= lc3b_pkg::m_idle;
                        end
                    end
            endcase
        end
    end

endmodule

`default_nettype wire
